// ==== hw/cache_array.sv ====
`timescale 1ns/1ps

module cache_array #(
	parameter type entry_t = logic,
	parameter int depth = cache_geom_pkg::num_lines
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   we,
	input  cache_geom_pkg::index_t index,
	input  entry_t                 wentry,
	output entry_t                 rentry
);

	entry_t mem [depth];

	// Reset wipes every entry, so the tag instance comes up all invalid.
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			for (int i = 0; i < depth; i++)
				mem[i] <= '0;
		end
		else if (we)
		begin
			mem[index] <= wentry;
		end
	end

	// Read is asynchronous so hit and dirty settle in the same cycle.
	assign rentry = mem[index];

endmodule

// ==== hw/cache_controller.sv ====
`timescale 1ns/1ps

module cache_controller (
	input  logic clk,
	input  logic rst,
	input  logic cs,
	input  logic we,
	output logic ack,
	input  logic hit,
	input  logic valid,
	input  logic dirty,
	output logic tag_we,
	output logic data_we,
	output logic set_dirty,
	output logic wdata_sel,
	output logic victim_sel,
	output logic rdata_sel,
	output logic dram_cs,
	output logic dram_we,
	input  logic dram_ack
);

	cache_ctrl_pkg::ctrl_state_t state;
	cache_ctrl_pkg::ctrl_state_t next_state;
	cache_ctrl_pkg::wdata_sel_t  wsel;
	logic                        ack_next;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= cache_ctrl_pkg::idle;
			ack <= 1'b0;
		end
		else
		begin
			state <= next_state;
			ack <= ack_next;
		end
	end

	// Ack is registered, so it is raised on the edge that enters the ack cycle.
	always_comb
	begin
		next_state = state;
		ack_next = 1'b0;
		case (state)
			cache_ctrl_pkg::idle:
			begin
				// After a read hit the CPU still holds cs during the ack cycle.
				if (cs && !ack)
				begin
					if (we)
						next_state = cache_ctrl_pkg::write;
					else
						next_state = cache_ctrl_pkg::read;
				end
			end
			cache_ctrl_pkg::read:
			begin
				if (hit)
				begin
					next_state = cache_ctrl_pkg::idle;
					ack_next = 1'b1;
				end
				else if (valid && dirty)
					next_state = cache_ctrl_pkg::write_back;
				else
					next_state = cache_ctrl_pkg::read_miss;
			end
			cache_ctrl_pkg::read_miss:
				next_state = cache_ctrl_pkg::read_mem;
			cache_ctrl_pkg::read_mem:
			begin
				if (dram_ack)
				begin
					next_state = cache_ctrl_pkg::read_data;
					ack_next = 1'b1;
				end
			end
			cache_ctrl_pkg::read_data:
				next_state = cache_ctrl_pkg::idle;
			cache_ctrl_pkg::write:
			begin
				if (hit)
				begin
					next_state = cache_ctrl_pkg::write_hit;
					ack_next = 1'b1;
				end
				else
					next_state = cache_ctrl_pkg::write_miss;
			end
			cache_ctrl_pkg::write_hit:
				next_state = cache_ctrl_pkg::idle;
			cache_ctrl_pkg::write_miss:
				next_state = cache_ctrl_pkg::write_mem;
			cache_ctrl_pkg::write_mem:
			begin
				if (dram_ack)
				begin
					next_state = cache_ctrl_pkg::write_data;
					ack_next = 1'b1;
				end
			end
			cache_ctrl_pkg::write_data:
				next_state = cache_ctrl_pkg::idle;
			cache_ctrl_pkg::write_back:
				next_state = cache_ctrl_pkg::write_back_mem;
			cache_ctrl_pkg::write_back_mem:
			begin
				// Victim is out, now fetch the requested word.
				if (dram_ack)
					next_state = cache_ctrl_pkg::read_miss;
			end
			default:
				next_state = cache_ctrl_pkg::idle;
		endcase
	end

	// Strobes are a plain decode of the current state.
	always_comb
	begin
		tag_we = 1'b0;
		data_we = 1'b0;
		set_dirty = 1'b0;
		wsel = cache_ctrl_pkg::wdata_cpu;
		victim_sel = 1'b0;
		rdata_sel = 1'b0;
		dram_cs = 1'b0;
		dram_we = 1'b0;
		case (state)
			cache_ctrl_pkg::read_mem:
				dram_cs = 1'b1;
			cache_ctrl_pkg::read_data:
			begin
				// Fill clean and return the fetched word directly.
				tag_we = 1'b1;
				data_we = 1'b1;
				wsel = cache_ctrl_pkg::wdata_dram;
				rdata_sel = 1'b1;
			end
			cache_ctrl_pkg::write_hit:
			begin
				tag_we = 1'b1;
				data_we = 1'b1;
				set_dirty = 1'b1;
			end
			cache_ctrl_pkg::write_mem:
			begin
				dram_cs = 1'b1;
				dram_we = 1'b1;
			end
			cache_ctrl_pkg::write_back:
				victim_sel = 1'b1;
			cache_ctrl_pkg::write_back_mem:
			begin
				victim_sel = 1'b1;
				dram_cs = 1'b1;
				dram_we = 1'b1;
			end
			default:
			begin
			end
		endcase
	end

	assign wdata_sel = wsel;

endmodule

// ==== hw/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

	// Controller states, one request in flight at a time.
	typedef enum logic [3:0] {
		idle,
		read,
		read_miss,
		read_mem,
		read_data,
		write,
		write_hit,
		write_miss,
		write_mem,
		write_data,
		write_back,
		write_back_mem
	} ctrl_state_t;

	// Source of the data array write port.
	typedef enum logic [0:0] {
		wdata_cpu,
		wdata_dram
	} wdata_sel_t;

endpackage

// ==== hw/cache_datapath.sv ====
`timescale 1ns/1ps

module cache_datapath (
	input  logic                  clk,
	input  logic                  rst,
	input  cache_geom_pkg::addr_t addr,
	input  cache_geom_pkg::word_t wdata,
	output cache_geom_pkg::word_t rdata,
	output logic                  hit,
	output logic                  valid,
	output logic                  dirty,
	input  logic                  tag_we,
	input  logic                  data_we,
	input  logic                  set_dirty,
	input  logic                  wdata_sel,
	input  logic                  victim_sel,
	input  logic                  rdata_sel,
	output cache_geom_pkg::addr_t dram_addr,
	output cache_geom_pkg::word_t dram_wdata,
	input  cache_geom_pkg::word_t dram_rdata
);

	cache_geom_pkg::index_t     index;
	cache_geom_pkg::tag_t       req_tag;
	cache_geom_pkg::tag_entry_t tag_rentry;
	cache_geom_pkg::tag_entry_t tag_wentry;
	cache_geom_pkg::word_t      data_rentry;
	cache_geom_pkg::word_t      data_wentry;
	cache_geom_pkg::word_t      fill_q;

	// Low bits pick the line, the rest are kept as the tag.
	assign index = addr[cache_geom_pkg::index_w-1:0];
	assign req_tag = addr[cache_geom_pkg::addr_w-1:cache_geom_pkg::index_w];

	// DRAM data is only valid in its ack cycle, so hold it for the fill cycle.
	always_ff @(posedge clk)
	begin
		fill_q <= dram_rdata;
	end

	assign hit = tag_rentry.valid && (tag_rentry.tag == req_tag);
	assign valid = tag_rentry.valid;
	assign dirty = tag_rentry.dirty;

	// Any tag write installs the request tag as a valid line.
	assign tag_wentry = '{valid: 1'b1, dirty: set_dirty, tag: req_tag};

	assign data_wentry = (wdata_sel == cache_ctrl_pkg::wdata_dram) ? fill_q : wdata;
	assign rdata = rdata_sel ? fill_q : data_rentry;

	// Victim writes go to the stored line's address with its stored data.
	assign dram_addr = victim_sel ? {tag_rentry.tag, index} : addr;
	assign dram_wdata = victim_sel ? data_rentry : wdata;

	cache_array #(
		.entry_t(cache_geom_pkg::tag_entry_t)
	) tag_array (
		.clk(clk),
		.rst(rst),
		.we(tag_we),
		.index(index),
		.wentry(tag_wentry),
		.rentry(tag_rentry)
	);

	cache_array #(
		.entry_t(cache_geom_pkg::word_t)
	) data_array (
		.clk(clk),
		.rst(rst),
		.we(data_we),
		.index(index),
		.wentry(data_wentry),
		.rentry(data_rentry)
	);

endmodule

// ==== hw/cache_geom_pkg.sv ====
package cache_geom_pkg;

	// Addresses count words, so one address names one 32-bit word.
	localparam int addr_w = 16;
	localparam int word_w = 32;

	// Direct-mapped with one word per line.
	localparam int index_w = 6;
	localparam int tag_w = addr_w - index_w;
	localparam int num_lines = 1 << index_w;

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [word_w-1:0] word_t;
	typedef logic [index_w-1:0] index_t;
	typedef logic [tag_w-1:0] tag_t;

	// Per-line bookkeeping kept beside the data array.
	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} tag_entry_t;

endpackage

// ==== hw/l1_cache_top.sv ====
`timescale 1ns/1ps

module l1_cache_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cs,
	input  logic                  we,
	input  cache_geom_pkg::addr_t addr,
	input  cache_geom_pkg::word_t wdata,
	output cache_geom_pkg::word_t rdata,
	output logic                  ack,
	output logic                  dram_cs,
	output logic                  dram_we,
	output cache_geom_pkg::addr_t dram_addr,
	output cache_geom_pkg::word_t dram_wdata,
	input  cache_geom_pkg::word_t dram_rdata,
	input  logic                  dram_ack
);

	// Status from the arrays.
	logic hit;
	logic valid;
	logic dirty;

	// Array and mux controls from the FSM.
	logic tag_we;
	logic data_we;
	logic set_dirty;
	logic wdata_sel;
	logic victim_sel;
	logic rdata_sel;

	cache_controller u_controller (
		.clk(clk),
		.rst(rst),
		.cs(cs),
		.we(we),
		.ack(ack),
		.hit(hit),
		.valid(valid),
		.dirty(dirty),
		.tag_we(tag_we),
		.data_we(data_we),
		.set_dirty(set_dirty),
		.wdata_sel(wdata_sel),
		.victim_sel(victim_sel),
		.rdata_sel(rdata_sel),
		.dram_cs(dram_cs),
		.dram_we(dram_we),
		.dram_ack(dram_ack)
	);

	cache_datapath u_datapath (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.wdata(wdata),
		.rdata(rdata),
		.hit(hit),
		.valid(valid),
		.dirty(dirty),
		.tag_we(tag_we),
		.data_we(data_we),
		.set_dirty(set_dirty),
		.wdata_sel(wdata_sel),
		.victim_sel(victim_sel),
		.rdata_sel(rdata_sel),
		.dram_addr(dram_addr),
		.dram_wdata(dram_wdata),
		.dram_rdata(dram_rdata)
	);

endmodule

// ==== l1_cache.f ====
hw/cache_geom_pkg.sv
hw/cache_ctrl_pkg.sv
hw/cache_array.sv
hw/cache_datapath.sv
hw/cache_controller.sv
hw/l1_cache_top.sv
sim/tb_clock_gen.sv
sim/dram_model.sv
sim/l1_cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	--top-module l1_cache_tb \
	-f l1_cache.f \
	-o sim_l1_cache

./obj_dir/sim_l1_cache | tee sim.log

if grep -q "All checks passed" sim.log
then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

// ==== sim/dram_model.sv ====
`timescale 1ns/1ps

module dram_model (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  dram_cs,
	input  logic                  dram_we,
	input  cache_geom_pkg::addr_t dram_addr,
	input  cache_geom_pkg::word_t dram_wdata,
	output cache_geom_pkg::word_t dram_rdata,
	output logic                  dram_ack
);

	cache_geom_pkg::word_t mem [1 << cache_geom_pkg::addr_w];
	logic waiting;
	int   count;

	// Preload mixes every address bit into the word.
	initial
	begin
		for (int i = 0; i < (1 << cache_geom_pkg::addr_w); i++)
			mem[i] = {~i[15:0], i[15:0]} ^ 32'h1357_9bdf;
		dram_rdata = '0;
	end

	always @(posedge clk)
	begin
		if (!rst)
		begin
			dram_ack <= 1'b0;
			waiting <= 1'b0;
			count <= 0;
		end
		else if (dram_ack)
			dram_ack <= 1'b0;
		else if (dram_cs)
		begin
			if (!waiting)
			begin
				// Random latency of 1 to 6 cycles.
				waiting <= 1'b1;
				count <= $urandom_range(6, 1) - 1;
			end
			else if (count == 0)
			begin
				if (dram_we)
					mem[dram_addr] <= dram_wdata;
				else
					dram_rdata <= mem[dram_addr];
				dram_ack <= 1'b1;
				waiting <= 1'b0;
			end
			else
				count <= count - 1;
		end
	end

endmodule

// ==== sim/l1_cache_tb.sv ====
`timescale 1ns/1ps

module l1_cache_tb;

	localparam int num_random = 200;
	localparam int num_requests = 7 + num_random;
	localparam int watchdog_cycles = num_requests * (6 + 2 * 6 + 4) + 16;

	logic                  clk;
	logic                  rst;
	logic                  cs;
	logic                  we;
	cache_geom_pkg::addr_t addr;
	cache_geom_pkg::word_t wdata;
	cache_geom_pkg::word_t rdata;
	logic                  ack;
	logic                  dram_cs;
	logic                  dram_we;
	cache_geom_pkg::addr_t dram_addr;
	cache_geom_pkg::word_t dram_wdata;
	cache_geom_pkg::word_t dram_rdata;
	logic                  dram_ack;

	// Reference memory and a shadow of the cache bookkeeping.
	cache_geom_pkg::word_t shadow [1 << cache_geom_pkg::addr_w];
	cache_geom_pkg::tag_t  m_tag [cache_geom_pkg::num_lines];
	logic                  m_valid [cache_geom_pkg::num_lines];
	logic                  m_dirty [cache_geom_pkg::num_lines];

	cache_geom_pkg::addr_t wr_addr_q [$];
	cache_geom_pkg::word_t wr_data_q [$];
	int                    dram_reads;
	int                    errors;
	int                    checks;

	tb_clock_gen clock_gen (
		.clk(clk),
		.rst(rst)
	);

	dram_model dram (
		.clk(clk),
		.rst(rst),
		.dram_cs(dram_cs),
		.dram_we(dram_we),
		.dram_addr(dram_addr),
		.dram_wdata(dram_wdata),
		.dram_rdata(dram_rdata),
		.dram_ack(dram_ack)
	);

	l1_cache_top UUT (
		.clk(clk),
		.rst(rst),
		.cs(cs),
		.we(we),
		.addr(addr),
		.wdata(wdata),
		.rdata(rdata),
		.ack(ack),
		.dram_cs(dram_cs),
		.dram_we(dram_we),
		.dram_addr(dram_addr),
		.dram_wdata(dram_wdata),
		.dram_rdata(dram_rdata),
		.dram_ack(dram_ack)
	);

	// Same pattern the DRAM model is loaded with.
	function automatic cache_geom_pkg::word_t preload_word(input int a);
		return {~a[15:0], a[15:0]} ^ 32'h1357_9bdf;
	endfunction

	function automatic cache_geom_pkg::word_t expected_read(input cache_geom_pkg::addr_t a);
		return shadow[a];
	endfunction

	function automatic cache_geom_pkg::addr_t expected_victim(input cache_geom_pkg::index_t idx);
		return {m_tag[idx], idx};
	endfunction

	task automatic check_word(input string name, input cache_geom_pkg::word_t exp,
		input cache_geom_pkg::word_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input cache_geom_pkg::addr_t exp,
		input cache_geom_pkg::addr_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (exp != act)
		begin
			errors++;
			$display("ERROR %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// Every completed DRAM transfer is logged on its ack cycle.
	always @(posedge clk)
	begin
		if (rst && dram_ack && dram_cs)
		begin
			if (dram_we)
			begin
				wr_addr_q.push_back(dram_addr);
				wr_data_q.push_back(dram_wdata);
			end
			else
				dram_reads++;
		end
	end

	// One CPU request, checked against the shadow model.
	task automatic access(input string name, input logic is_write,
		input cache_geom_pkg::addr_t a, input cache_geom_pkg::word_t d);
		cache_geom_pkg::index_t idx;
		cache_geom_pkg::tag_t   tg;
		cache_geom_pkg::addr_t  victim;
		cache_geom_pkg::word_t  victim_data;
		logic                   exp_hit;
		logic                   exp_evict;
		int                     wr_before;
		int                     rd_before;
		int                     cycles;
		idx = a[cache_geom_pkg::index_w-1:0];
		tg = a[cache_geom_pkg::addr_w-1:cache_geom_pkg::index_w];
		exp_hit = m_valid[idx] && (m_tag[idx] == tg);
		exp_evict = !is_write && !exp_hit && m_valid[idx] && m_dirty[idx];
		victim = expected_victim(idx);
		victim_data = expected_read(victim);
		wr_before = wr_addr_q.size();
		rd_before = dram_reads;

		@(posedge clk);
		cs <= 1'b1;
		we <= is_write;
		addr <= a;
		wdata <= d;
		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
		end
		while (!ack);
		if (!is_write)
			check_word({name, " rdata"}, expected_read(a), rdata);
		cs <= 1'b0;
		we <= 1'b0;

		if (exp_hit)
		begin
			check_count({name, " ack cycles"}, 2, cycles - 1);
			check_count({name, " dram writes"}, 0, wr_addr_q.size() - wr_before);
			check_count({name, " dram reads"}, 0, dram_reads - rd_before);
			if (is_write)
				m_dirty[idx] = 1'b1;
		end
		else if (is_write)
		begin
			// Write miss goes around the cache.
			check_count({name, " dram writes"}, 1, wr_addr_q.size() - wr_before);
			if (wr_addr_q.size() > wr_before)
			begin
				check_addr({name, " dram write addr"}, a, wr_addr_q[wr_before]);
				check_word({name, " dram write data"}, d, wr_data_q[wr_before]);
			end
		end
		else
		begin
			check_count({name, " dram reads"}, 1, dram_reads - rd_before);
			check_count({name, " dram writes"}, exp_evict ? 1 : 0,
				wr_addr_q.size() - wr_before);
			if (exp_evict && wr_addr_q.size() > wr_before)
			begin
				check_addr({name, " victim addr"}, victim, wr_addr_q[wr_before]);
				check_word({name, " victim data"}, victim_data, wr_data_q[wr_before]);
			end
			m_tag[idx] = tg;
			m_valid[idx] = 1'b1;
			m_dirty[idx] = 1'b0;
		end
		if (is_write)
			shadow[a] = d;
	endtask

	initial
	begin
		cache_geom_pkg::addr_t a;
		cache_geom_pkg::addr_t conflict;
		logic                  w;

		cs = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		dram_reads = 0;
		errors = 0;
		checks = 0;
		void'($urandom(16));
		for (int i = 0; i < (1 << cache_geom_pkg::addr_w); i++)
			shadow[i] = preload_word(i);
		for (int i = 0; i < cache_geom_pkg::num_lines; i++)
		begin
			m_tag[i] = '0;
			m_valid[i] = 1'b0;
			m_dirty[i] = 1'b0;
		end

		wait (rst === 1'b1);
		@(posedge clk);
		check_count("reset ack", 0, int'(ack));
		check_count("reset dram_cs", 0, int'(dram_cs));

		a = 16'h0012;
		conflict = a + (16'd5 << cache_geom_pkg::index_w);
		access("first read miss", 1'b0, a, '0);
		access("read hit", 1'b0, a, '0);
		access("write hit", 1'b1, a, $urandom);
		access("read after write", 1'b0, a, '0);
		access("dirty eviction", 1'b0, conflict, '0);
		access("write miss", 1'b1, a + (16'd9 << cache_geom_pkg::index_w), $urandom);
		access("old line hit", 1'b0, conflict, '0);

		// Two tags over four indices keep conflicts frequent.
		for (int n = 0; n < num_random; n++)
		begin
			a = {($urandom_range(1, 0) == 0) ? 10'h011 : 10'h2a3,
				6'($urandom_range(3, 0))};
			w = 1'($urandom_range(1, 0));
			access("random mix", w, a, $urandom);
		end

		repeat (2) @(posedge clk);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Bounds the run by the worst request latency.
	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout: the cache stopped answering requests");
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int half_period = 20,
	parameter int reset_cycles = 16
) (
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// Reset is active low and released on a rising edge.
	initial
	begin
		rst = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b1;
	end

endmodule
